// File: common/tpu_defines.svh
//////////////////////////////////////////////////////////////////////
// Thread processing unit front end
// Word, slot and field widths shared by every block
//////////////////////////////////////////////////////////////////////

`ifndef TPU_DEFINES_SVH
`define TPU_DEFINES_SVH

`define TPU_WORD_W		32	// Host and memory word
`define TPU_SLOT_DEPTH	32	// Instruction words per program slot
`define TPU_ADDR_W		6	// Slot bit plus offset
`define TPU_OFFS_W		5	// Offset inside one slot
`define TPU_LEN_W		6	// Program length, 0 to slot depth
`define TPU_ISSUE_W		8	// Issue number
`define TPU_TID_W		8	// Thread identifier

`endif

// File: common/tpu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Thread processing unit front end types
// Instruction word layout, opcodes and front-end FSM states
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tpu_defines.svh"

package tpu_pkg;

	typedef logic [`TPU_ISSUE_W-1:0]	issue_no_t;
	typedef logic [`TPU_TID_W-1:0]		thread_id_t;
	typedef logic [`TPU_LEN_W-1:0]		prog_len_t;

	typedef enum logic [3:0] {
		OP_NOP		= 4'h0,
		OP_ADD		= 4'h1,
		OP_MUL		= 4'h2,
		OP_LOAD		= 4'h3,
		OP_STORE	= 4'h4,
		OP_HALT		= 4'h5
	} opcode_t;

	// One memory word per instruction
	typedef struct packed {
		logic			valid;
		opcode_t		opcode;
		logic [26:0]	operand;
	} instr_t;

	typedef enum logic [1:0] {
		FE_INIT,	// Waiting for execution enable
		FE_HEADER,	// Expecting issue number
		FE_THREAD,	// Expecting thread identifier
		FE_INSTR	// Instruction words until term
	} fe_state_t;

endpackage

`default_nettype wire

// File: common/wb_if.sv
//////////////////////////////////////////////////////////////////////
// Wishbone classic bus toward the instruction memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

interface wb_if;

	logic						cyc;
	logic						stb;
	logic						we;
	logic [`TPU_ADDR_W-1:0]		adr;
	logic [`TPU_WORD_W-1:0]		dat_w;
	logic [`TPU_WORD_W-1:0]		dat_r;
	logic						ack;

	modport master (
		output	cyc, stb, we, adr, dat_w,
		input	dat_r, ack
	);

	modport slave (
		input	cyc, stb, we, adr, dat_w,
		output	dat_r, ack
	);

endinterface

`default_nettype wire

// File: common/prog_if.sv
//////////////////////////////////////////////////////////////////////
// Program slot hand-off from the front end to the fetch unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

interface prog_if;

	logic					valid;		// Slot holds a finished program
	logic					slot;
	tpu_pkg::prog_len_t		length;
	tpu_pkg::issue_no_t		issue_no;
	tpu_pkg::thread_id_t	thread_id;
	logic					rel;		// Slot release pulse

	modport source (
		output	valid, slot, length, issue_no, thread_id,
		input	rel
	);

	modport sink (
		input	valid, slot, length, issue_no, thread_id,
		output	rel
	);

endinterface

`default_nettype wire

// File: front_end/front_end.sv
//////////////////////////////////////////////////////////////////////
// Front end
// Takes host words and writes programs into two alternating slots
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

module front_end (
	input  logic					clock,
	input  logic					reset,
	input  logic					en_exe,
	input  logic					req,
	input  logic					term,
	input  logic [`TPU_WORD_W-1:0]	word,
	output logic					nack,
	wb_if.master					wb,
	prog_if.source					prog
);

	tpu_pkg::fe_state_t				state;
	logic [1:0]						occupied;		// Finished, not yet drained
	logic							wr_slot;
	logic							rd_slot;
	tpu_pkg::prog_len_t				count;
	tpu_pkg::prog_len_t				slot_len [2];
	tpu_pkg::issue_no_t				slot_issue [2];
	tpu_pkg::thread_id_t			slot_tid [2];
	logic							pending;
	logic [`TPU_ADDR_W-1:0]			wr_adr;
	logic [`TPU_WORD_W-1:0]			wr_dat;
	logic							full;
	logic							busy;
	logic							closing;
	logic							strobe;
	logic							overflow;
	logic							accept;
	logic							take_instr;

	//////////////////////////////////////////////////////////////////////
	// Host handshake

	assign full			= &occupied;
	assign busy			= pending | (full & (state == tpu_pkg::FE_HEADER));
	assign closing		= term & (state == tpu_pkg::FE_INSTR);	// Term only closes in INSTR
	assign strobe		= req | closing;
	assign overflow		= req & ~closing & (state == tpu_pkg::FE_INSTR) &
						  (count == `TPU_LEN_W'(`TPU_SLOT_DEPTH));
	assign accept		= strobe & en_exe & ~busy & ~overflow & (state != tpu_pkg::FE_INIT);
	assign take_instr	= accept & ~closing & (state == tpu_pkg::FE_INSTR);

	always_ff @(posedge clock) begin
		if (reset) begin
			nack <= 1'b0;
		end else begin
			nack <= strobe & ~accept;	// Refusal shows one cycle later
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Program FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state	<= tpu_pkg::FE_INIT;
			count	<= '0;
			wr_slot	<= 1'b0;
		end else begin
			case (state)
				tpu_pkg::FE_INIT: begin
					if (en_exe) state <= tpu_pkg::FE_HEADER;
				end
				tpu_pkg::FE_HEADER: begin
					if (accept) state <= tpu_pkg::FE_THREAD;
				end
				tpu_pkg::FE_THREAD: begin
					if (accept) state <= tpu_pkg::FE_INSTR;
				end
				tpu_pkg::FE_INSTR: begin
					if (accept && closing) begin
						state	<= tpu_pkg::FE_HEADER;
						count	<= '0;
						wr_slot	<= ~wr_slot;	// Next program goes to the other slot
					end else if (accept) begin
						count	<= count + 1'b1;
					end
				end
				default: state <= tpu_pkg::FE_INIT;
			endcase
		end
	end

	// Slot details are payload
	always_ff @(posedge clock) begin
		if (accept && state == tpu_pkg::FE_HEADER) slot_issue[wr_slot] <= word[`TPU_ISSUE_W-1:0];
		if (accept && state == tpu_pkg::FE_THREAD) slot_tid[wr_slot] <= word[`TPU_TID_W-1:0];
		if (accept && closing) slot_len[wr_slot] <= count;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			occupied	<= 2'b00;
			rd_slot		<= 1'b0;
		end else begin
			if (accept && closing) occupied[wr_slot] <= 1'b1;
			if (prog.rel) begin
				occupied[rd_slot]	<= 1'b0;
				rd_slot				<= ~rd_slot;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction write toward memory

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (pending && wb.ack) begin
			pending <= 1'b0;
		end else if (take_instr) begin
			pending <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (take_instr) begin
			wr_adr	<= {wr_slot, count[`TPU_OFFS_W-1:0]};
			wr_dat	<= word;
		end
	end

	assign wb.cyc		= pending;
	assign wb.stb		= pending;
	assign wb.we		= 1'b1;		// Write-only master
	assign wb.adr		= wr_adr;
	assign wb.dat_w		= wr_dat;

	assign prog.valid		= occupied[rd_slot];
	assign prog.slot		= rd_slot;
	assign prog.length		= slot_len[rd_slot];
	assign prog.issue_no	= slot_issue[rd_slot];
	assign prog.thread_id	= slot_tid[rd_slot];

	// A slot waiting for fetch must never be overwritten
	a_no_write_occupied: assert property (@(posedge clock) disable iff (reset)
		wb.stb && wb.we |-> !occupied[wb.adr[`TPU_ADDR_W-1]])
		else $error("front_end: write into occupied slot %0d", wb.adr[`TPU_ADDR_W-1]);

endmodule

`default_nettype wire

// File: logic/instr_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Instruction memory arbiter
// Round-robin grant of two Wishbone masters onto one slave
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module instr_arbiter (
	input  logic	clock,
	input  logic	reset,
	wb_if.slave		fe,
	wb_if.slave		fetch,
	wb_if.master	mem
);

	logic	owner;		// 0 front end, 1 fetch
	logic	held;		// Grant locked for a cycle in progress
	logic	pick;
	logic	cur;
	logic	owner_cyc;

	// Prefer the master that did not own the bus last
	always_comb begin
		if (fe.cyc && fetch.cyc) begin
			pick = ~owner;
		end else begin
			pick = fetch.cyc;
		end
	end

	assign cur			= held ? owner : pick;
	assign owner_cyc	= owner ? fetch.cyc : fe.cyc;

	always_ff @(posedge clock) begin
		if (reset) begin
			held	<= 1'b0;
			owner	<= 1'b0;
		end else if (held) begin
			if (!owner_cyc) held <= 1'b0;	// Cycle ended
		end else if (fe.cyc || fetch.cyc) begin
			held	<= 1'b1;
			owner	<= pick;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus routing

	assign mem.cyc		= cur ? fetch.cyc   : fe.cyc;
	assign mem.stb		= cur ? fetch.stb   : fe.stb;
	assign mem.we		= cur ? fetch.we    : fe.we;
	assign mem.adr		= cur ? fetch.adr   : fe.adr;
	assign mem.dat_w	= cur ? fetch.dat_w : fe.dat_w;

	assign fe.ack		= mem.ack & ~cur;
	assign fetch.ack	= mem.ack & cur;
	assign fe.dat_r		= cur ? '0 : mem.dat_r;
	assign fetch.dat_r	= cur ? mem.dat_r : '0;

	// An ack answers the strobe of the master holding the grant
	a_ack_owner: assert property (@(posedge clock) disable iff (reset)
		mem.ack |-> held &&
			(owner ? ($past(fetch.stb) && !fe.ack) : ($past(fe.stb) && !fetch.ack)))
		else $error("instr_arbiter: ack to master without grant");

endmodule

`default_nettype wire

// File: logic/instr_memory.sv
//////////////////////////////////////////////////////////////////////
// Instruction memory
// Two program slots behind a Wishbone classic slave port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

module instr_memory (
	input  logic	clock,
	input  logic	reset,
	wb_if.slave		wb
);

	logic [`TPU_WORD_W-1:0]		words [2*`TPU_SLOT_DEPTH];
	logic [`TPU_WORD_W-1:0]		rd_q;
	logic						ack_q;
	logic						hit;

	// One access per strobe, blocked while acking
	assign hit = wb.cyc & wb.stb & ~ack_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;	// Single-cycle registered ack
		end
	end

	always_ff @(posedge clock) begin
		if (hit) begin
			if (wb.we) words[wb.adr] <= wb.dat_w;
			rd_q <= words[wb.adr];
		end
	end

	assign wb.ack	= ack_q;
	assign wb.dat_r	= rd_q;

endmodule

`default_nettype wire

// File: logic/instr_fetch.sv
//////////////////////////////////////////////////////////////////////
// Fetch unit
// Reads a finished slot back, emits instructions, commits the issue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

module instr_fetch (
	input  logic					clock,
	input  logic					reset,
	prog_if.sink					prog,
	wb_if.master					wb,
	output logic					out_valid,
	input  logic					out_ready,
	output tpu_pkg::instr_t			out_instr,
	output tpu_pkg::thread_id_t		out_thread_id,
	output logic					commit_valid,
	output tpu_pkg::issue_no_t		commit_issue_no
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_READ,
		F_EMIT,
		F_COMMIT
	} fetch_state_t;

	fetch_state_t			state;
	logic					slot;
	tpu_pkg::prog_len_t		length;
	tpu_pkg::prog_len_t		count;		// Words read so far
	logic					rd_pend;
	logic					last;

	// Stop at program length or after a HALT
	assign last = (count == length) || (out_instr.opcode == tpu_pkg::OP_HALT);

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= F_IDLE;
			rd_pend		<= 1'b0;
			out_valid	<= 1'b0;
			count		<= '0;
		end else begin
			case (state)
				F_IDLE: begin
					if (prog.valid) begin
						count <= '0;
						if (prog.length == '0) begin
							state	<= F_COMMIT;	// Empty program
						end else begin
							state	<= F_READ;
							rd_pend	<= 1'b1;
						end
					end
				end
				F_READ: begin
					if (wb.ack) begin
						rd_pend		<= 1'b0;
						out_valid	<= 1'b1;
						count		<= count + 1'b1;
						state		<= F_EMIT;
					end
				end
				F_EMIT: begin
					if (out_ready) begin
						out_valid <= 1'b0;
						if (last) begin
							state	<= F_COMMIT;
						end else begin
							state	<= F_READ;
							rd_pend	<= 1'b1;
						end
					end
				end
				default: state <= F_IDLE;	// Commit lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == F_IDLE && prog.valid) begin
			slot			<= prog.slot;
			length			<= prog.length;
			out_thread_id	<= prog.thread_id;
			commit_issue_no	<= prog.issue_no;
		end
		if (state == F_READ && wb.ack) out_instr <= tpu_pkg::instr_t'(wb.dat_r);
	end

	assign wb.cyc		= rd_pend;
	assign wb.stb		= rd_pend;
	assign wb.we		= 1'b0;		// Read-only master
	assign wb.adr		= {slot, count[`TPU_OFFS_W-1:0]};
	assign wb.dat_w		= '0;

	assign commit_valid	= (state == F_COMMIT);
	assign prog.rel		= commit_valid;

	// Held output under back-pressure
	a_out_hold: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_instr))
		else $error("instr_fetch: out_instr changed while stalled");

endmodule

`default_nettype wire

// File: logic/tpu_front_top.sv
//////////////////////////////////////////////////////////////////////
// Front end top level
// Loader and fetch unit sharing one instruction memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

module tpu_front_top (
	input  logic					clock,
	input  logic					reset,
	input  logic					en_exe,
	input  logic					req,
	input  logic					term,
	input  logic [`TPU_WORD_W-1:0]	word,
	output logic					nack,
	output logic					out_valid,
	input  logic					out_ready,
	output tpu_pkg::instr_t			out_instr,
	output tpu_pkg::thread_id_t		out_thread_id,
	output logic					commit_valid,
	output tpu_pkg::issue_no_t		commit_issue_no
);

	wb_if	fe_bus ();
	wb_if	fetch_bus ();
	wb_if	mem_bus ();
	prog_if	prog_link ();

	front_end u_front_end (
		.clock			(clock),
		.reset			(reset),
		.en_exe			(en_exe),
		.req			(req),
		.term			(term),
		.word			(word),
		.nack			(nack),
		.wb				(fe_bus),
		.prog			(prog_link)
	);

	instr_arbiter u_instr_arbiter (
		.clock			(clock),
		.reset			(reset),
		.fe				(fe_bus),
		.fetch			(fetch_bus),
		.mem			(mem_bus)
	);

	instr_memory u_instr_memory (
		.clock			(clock),
		.reset			(reset),
		.wb				(mem_bus)
	);

	instr_fetch u_instr_fetch (
		.clock				(clock),
		.reset				(reset),
		.prog				(prog_link),
		.wb					(fetch_bus),
		.out_valid			(out_valid),
		.out_ready			(out_ready),
		.out_instr			(out_instr),
		.out_thread_id		(out_thread_id),
		.commit_valid		(commit_valid),
		.commit_issue_no	(commit_issue_no)
	);

endmodule

`default_nettype wire

// File: sim/tpu_front_tb.sv
//////////////////////////////////////////////////////////////////////
// Front end testbench
// Loads programs through the host port and checks the fetch output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tpu_defines.svh"

module tpu_front_tb;

	localparam int TIMEOUT_CYCLES	= 600;	// Longest wait for any output
	localparam int MAX_TRIES		= 20;	// Host retries per word

	logic					clock;
	logic					reset;
	logic					en_exe;
	logic					req;
	logic					term;
	logic [`TPU_WORD_W-1:0]	word;
	logic					nack;
	logic					out_valid;
	logic					out_ready;
	tpu_pkg::instr_t		out_instr;
	tpu_pkg::thread_id_t	out_thread_id;
	logic					commit_valid;
	tpu_pkg::issue_no_t		commit_issue_no;
	integer					seed;

	// Programs under test
	tpu_pkg::instr_t		prog_words [2][`TPU_SLOT_DEPTH+1];
	int						prog_len [2];
	tpu_pkg::issue_no_t		prog_issue [2];
	tpu_pkg::thread_id_t	prog_tid [2];

	tpu_front_top DUT (
		.clock				(clock),
		.reset				(reset),
		.en_exe				(en_exe),
		.req				(req),
		.term				(term),
		.word				(word),
		.nack				(nack),
		.out_valid			(out_valid),
		.out_ready			(out_ready),
		.out_instr			(out_instr),
		.out_thread_id		(out_thread_id),
		.commit_valid		(commit_valid),
		.commit_issue_no	(commit_issue_no)
	);

	always #5 clock = ~clock;	// 10 ns period

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_instr(input tpu_pkg::instr_t got, input tpu_pkg::instr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL out_instr got 0x%h expected 0x%h", got, exp));
	endtask

	task automatic check_thread(input tpu_pkg::thread_id_t got, input tpu_pkg::thread_id_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL out_thread_id got 0x%h expected 0x%h", got, exp));
	endtask

	task automatic check_issue(input tpu_pkg::issue_no_t got, input tpu_pkg::issue_no_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL commit_issue_no got 0x%h expected 0x%h", got, exp));
	endtask

	task automatic check_nack(input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL nack got 0x%h expected 0x%h", got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Program setup and host side

	function automatic tpu_pkg::instr_t make_instr(input tpu_pkg::opcode_t op,
			input logic [26:0] operand);
		tpu_pkg::instr_t i;
		i.valid		= 1'b1;
		i.opcode	= op;
		i.operand	= operand;
		return i;
	endfunction

	// Opcodes cycle NOP to STORE with random operands
	task automatic set_program(input int idx, input int len, input tpu_pkg::issue_no_t issue,
			input tpu_pkg::thread_id_t tid);
		logic [31:0] rnd;
		prog_len[idx]	= len;
		prog_issue[idx]	= issue;
		prog_tid[idx]	= tid;
		for (int k = 0; k < len; k++) begin
			rnd = $random(seed);
			prog_words[idx][k] = make_instr(tpu_pkg::opcode_t'(4'(k % 5)), rnd[26:0]);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// One attempt whose nack shows right after that edge
	task automatic host_offer(input logic [31:0] w, input logic is_term, output logic refused);
		req		= ~is_term;
		term	= is_term;
		word	= w;
		@(posedge clock);
		#1;
		req		= 1'b0;
		term	= 1'b0;
		refused	= nack;
	endtask

	task automatic host_send(input logic [31:0] w, input logic is_term);
		logic	refused;
		int		tries;
		tries	= 0;
		refused	= 1'b1;
		while (refused) begin
			if (tries == MAX_TRIES) stop_with_failure("host word was refused on every retry");
			host_offer(w, is_term, refused);
			tries++;
		end
	endtask

	task automatic send_header(input int idx);
		host_send(`TPU_WORD_W'(prog_issue[idx]), 1'b0);
		host_send(`TPU_WORD_W'(prog_tid[idx]), 1'b0);
	endtask

	task automatic load_program(input int idx);
		send_header(idx);
		for (int k = 0; k < prog_len[idx]; k++) host_send(prog_words[idx][k], 1'b0);
		host_send('0, 1'b1);	// Term strobe
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output side

	task automatic collect_one(input tpu_pkg::instr_t exp_i, input tpu_pkg::thread_id_t exp_t,
			input int gap_max);
		int waited;
		int gap;
		waited		= 0;
		out_ready	= 1'b0;
		while (!out_valid) begin
			if (waited == TIMEOUT_CYCLES) stop_with_failure("timeout waiting for out_valid");
			idle_cycles(1);
			waited++;
		end
		check_instr(out_instr, exp_i);
		check_thread(out_thread_id, exp_t);
		gap = (gap_max > 0) ? (($random(seed) & 32'h7fffffff) % (gap_max + 1)) : 0;
		idle_cycles(gap);
		out_ready = 1'b1;
		idle_cycles(1);	// Handshake edge
		out_ready = 1'b0;
	endtask

	task automatic wait_commit(input tpu_pkg::issue_no_t exp_issue);
		int waited;
		waited = 0;
		while (!commit_valid) begin
			if (out_valid) stop_with_failure("instruction emitted past the end of the program");
			if (waited == TIMEOUT_CYCLES) stop_with_failure("timeout waiting for commit_valid");
			idle_cycles(1);
			waited++;
		end
		check_issue(commit_issue_no, exp_issue);
		idle_cycles(1);
		if (commit_valid) stop_with_failure("commit_valid lasted more than one cycle");
	endtask

	// Expected stream ends at the length or after the first HALT
	task automatic collect_program(input int idx, input int gap_max);
		logic halted;
		halted = 1'b0;
		for (int k = 0; k < prog_len[idx] && !halted; k++) begin
			collect_one(prog_words[idx][k], prog_tid[idx], gap_max);
			halted = (prog_words[idx][k].opcode == tpu_pkg::OP_HALT);
		end
		wait_commit(prog_issue[idx]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic run_program(input int gap_max);
		fork
			load_program(0);
			collect_program(0, gap_max);
		join
	endtask

	task automatic test_back_pressure();
		logic refused;
		set_program(0, 4, 8'h41, 8'h51);
		set_program(1, 3, 8'h42, 8'h52);
		load_program(0);
		load_program(1);
		host_offer(32'h0000_0043, 1'b0, refused);	// Both slots full
		check_nack(refused, 1'b1);
		collect_program(0, 0);
		collect_program(1, 0);
	endtask

	task automatic test_refused_words();
		logic refused;
		set_program(0, 2, 8'h61, 8'h71);
		fork
			begin
				send_header(0);
				host_send(prog_words[0][0], 1'b0);
				en_exe = 1'b0;
				idle_cycles(3);
				host_offer(32'h0abc_1234, 1'b0, refused);
				check_nack(refused, 1'b1);
				en_exe = 1'b1;
				host_send(prog_words[0][1], 1'b0);
				host_send('0, 1'b1);
			end
			collect_program(0, 0);
		join
		set_program(0, `TPU_SLOT_DEPTH, 8'h62, 8'h72);
		fork
			begin
				send_header(0);
				for (int k = 0; k < `TPU_SLOT_DEPTH; k++) host_send(prog_words[0][k], 1'b0);
				idle_cycles(3);	// Last write retired
				host_offer(32'h0fed_cba9, 1'b0, refused);
				check_nack(refused, 1'b1);
				host_send('0, 1'b1);
			end
			collect_program(0, 0);
		join
	endtask

	initial begin
		clock		= 1'b0;
		reset		= 1'b1;
		en_exe		= 1'b0;
		req			= 1'b0;
		term		= 1'b0;
		word		= '0;
		out_ready	= 1'b0;
		seed		= 32'h5a3648f2;
		idle_cycles(16);
		reset		= 1'b0;
		en_exe		= 1'b1;
		check_nack(nack, 1'b0);
		if (out_valid !== 1'b0 || commit_valid !== 1'b0)
			stop_with_failure("output not low right after reset");

		set_program(0, 5, 8'h11, 8'h21);	// Straight program
		run_program(0);
		set_program(0, 5, 8'h12, 8'h22);
		prog_words[0][2] = make_instr(tpu_pkg::OP_HALT, 27'h0);
		run_program(0);
		set_program(0, 0, 8'h13, 8'h23);	// Term right after thread word
		run_program(0);
		test_back_pressure();
		test_refused_words();
		set_program(0, 12, 8'h14, 8'h24);
		run_program(4);	// Random ready gaps

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tpu_front_top.f
+incdir+common
common/tpu_pkg.sv
common/wb_if.sv
common/prog_if.sv
front_end/front_end.sv
logic/instr_arbiter.sv
logic/instr_memory.sv
logic/instr_fetch.sv
logic/tpu_front_top.sv
sim/tpu_front_tb.sv

// File: Makefile
# Verilator build and run of the front-end testbench

SOURCES = $(shell grep -v '^+' tpu_front_top.f) common/tpu_defines.svh

.PHONY: all run clean

all: run

obj_dir/Vtpu_front_tb: tpu_front_top.f $(SOURCES)
	verilator --binary --timing --assert --top-module tpu_front_tb -f tpu_front_top.f

run: obj_dir/Vtpu_front_tb
	./obj_dir/Vtpu_front_tb

clean:
	rm -rf obj_dir
